// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;

    localparam logic [2:0] ST_FETCH  = 3'd0;
    localparam logic [2:0] ST_DECODE = 3'd1;
    localparam logic [2:0] ST_EXEC   = 3'd2;
    localparam logic [2:0] ST_MEM    = 3'd3;
    localparam logic [2:0] ST_WB     = 3'd4;

    // One instruction word seen as the R, I, S and B layouts.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } inst_u;

endpackage

`default_nettype wire

// File: common/cpu_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_ctrl_if;

    logic       ir_load;
    logic       pc_step;
    logic       pc_branch;
    logic       reg_write;
    logic       wb_from_mem;
    logic       alu_src_imm;
    logic [2:0] alu_op;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;   // Selects SUB over ADD for R-type.
    logic       alu_zero;

    modport fsm (
        output ir_load, pc_step, pc_branch, reg_write, wb_from_mem, alu_src_imm, alu_op,
        input  opcode, funct3, funct7_b5, alu_zero
    );

    modport decode (
        input  ir_load,
        output opcode, funct3, funct7_b5
    );

    modport pc (
        input  pc_step, pc_branch
    );

    modport exec (
        input  reg_write, wb_from_mem, alu_src_imm, alu_op,
        output alu_zero
    );

endinterface

`default_nettype wire

// File: logic/pc_counter.sv
`timescale 1ns/100ps
`default_nettype none

module pc_counter import cpu_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    cpu_ctrl_if.pc          ctrl,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_nxt;

    // Branch offset is relative to the branch itself.
    always_comb begin
        pc_nxt = pc_o;
        if (ctrl.pc_branch) begin
            pc_nxt = pc_o + imm_i;
        end else if (ctrl.pc_step) begin
            pc_nxt = pc_o + XLEN'(4);
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pc_o <= '0;
        end else begin
            pc_o <= pc_nxt;
        end
    end

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!RESET)
        pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESET,
    cpu_ctrl_if.decode            ctrl,
    input  logic [XLEN-1:0]       mem_rdata_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o
);

    inst_u ir;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= mem_rdata_i;
        end
    end

    assign ctrl.opcode    = ir.r.opcode;
    assign ctrl.funct3    = ir.r.funct3;
    assign ctrl.funct7_b5 = ir.r.funct7[5];

    assign rs1_o = ir.r.rs1;
    assign rs2_o = ir.r.rs2;
    assign rd_o  = ir.r.rd;

    // Sign-extended immediate, I format unless store or branch.
    always_comb begin
        case (ir.r.opcode)
            OPC_STORE:  imm_o = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            OPC_BRANCH: imm_o = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                                 ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            default:    imm_o = {{20{ir.i.imm[11]}}, ir.i.imm};
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESET,
    cpu_ctrl_if.exec              ctrl,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       alu_res_i,
    input  logic [XLEN-1:0]       mem_rdata_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic [XLEN-1:0] load_q;
    logic [XLEN-1:0] wr_data;

    // Sampled through MEM, the last sample is the completing cycle.
    always_ff @(posedge CLK) begin
        if (ctrl.wb_from_mem && !ctrl.reg_write) begin
            load_q <= mem_rdata_i;
        end
    end

    assign wr_data = ctrl.wb_from_mem ? load_q : alu_res_i;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && rd_i != '0) begin
            regs[rd_i] <= wr_data;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    a_x0_zero: assert property (@(posedge CLK) disable iff (!RESET)
        rs1_i == '0 |-> rs1_data_o == '0);

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit import cpu_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    cpu_ctrl_if.exec        ctrl,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] alu_res_o
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] res_nxt;

    assign op_b = ctrl.alu_src_imm ? imm_i : rs2_data_i;
    assign diff = rs1_data_i - op_b;

    // Branch compare.
    assign ctrl.alu_zero = (diff == '0);

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: res_nxt = diff;
            ALU_AND: res_nxt = rs1_data_i & op_b;
            ALU_OR:  res_nxt = rs1_data_i | op_b;
            ALU_XOR: res_nxt = rs1_data_i ^ op_b;
            default: res_nxt = rs1_data_i + op_b;
        endcase
    end

    // Operands hold from DECODE to WB, so the result stays put after EXEC.
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            alu_res_o <= '0;
        end else begin
            alu_res_o <= res_nxt;
        end
    end

endmodule

`default_nettype wire

// File: cpu/control_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module control_fsm import cpu_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    cpu_ctrl_if.fsm         ctrl,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] alu_res_i,
    input  logic [XLEN-1:0] store_data_i,
    input  logic            mem_ready_i,
    output logic            mem_req_o,
    output logic            mem_write_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o
);

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       is_op;
    logic       is_op_imm;
    logic       is_mem;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       br_taken;
    logic       xfer_done;

    assign is_op     = (ctrl.opcode == OPC_OP);
    assign is_op_imm = (ctrl.opcode == OPC_OP_IMM);
    assign is_load   = (ctrl.opcode == OPC_LOAD);
    assign is_store  = (ctrl.opcode == OPC_STORE);
    assign is_branch = (ctrl.opcode == OPC_BRANCH);
    assign is_mem    = is_load || is_store;
    assign xfer_done = mem_req_o && mem_ready_i;

    // funct3 bit 0 tells BNE from BEQ.
    assign br_taken = is_branch && (ctrl.funct3[0] ? !ctrl.alu_zero : ctrl.alu_zero);

    assign ctrl.ir_load     = (state == ST_FETCH) && xfer_done;
    assign ctrl.alu_src_imm = is_op_imm || is_mem;
    assign ctrl.wb_from_mem = is_load && (state == ST_MEM || state == ST_WB);
    assign ctrl.reg_write   = (state == ST_WB) && !is_store;
    assign ctrl.pc_branch   = (state == ST_EXEC) && br_taken;
    assign ctrl.pc_step     = (state == ST_WB) ||
                              (state == ST_EXEC && !br_taken && !is_mem && !is_op && !is_op_imm);

    always_comb begin
        ctrl.alu_op = ALU_ADD;
        if (is_branch) begin
            ctrl.alu_op = ALU_SUB;
        end else if (is_op) begin
            case (ctrl.funct3)
                3'b000:  ctrl.alu_op = ctrl.funct7_b5 ? ALU_SUB : ALU_ADD;
                3'b100:  ctrl.alu_op = ALU_XOR;
                3'b110:  ctrl.alu_op = ALU_OR;
                3'b111:  ctrl.alu_op = ALU_AND;
                default: ctrl.alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FETCH:  if (xfer_done) state_nxt = ST_DECODE;
            ST_DECODE: state_nxt = ST_EXEC;
            ST_EXEC: begin
                if (is_mem)                  state_nxt = ST_MEM;
                else if (is_op || is_op_imm) state_nxt = ST_WB;
                else                         state_nxt = ST_FETCH;
            end
            ST_MEM:    if (xfer_done) state_nxt = ST_WB;
            default:   state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state <= ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // First cycle of FETCH or MEM raises the request, ready drops it.
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            mem_req_o   <= 1'b0;
            mem_write_o <= 1'b0;
        end else if (mem_req_o) begin
            if (mem_ready_i) begin
                mem_req_o   <= 1'b0;
                mem_write_o <= 1'b0;
            end
        end else if (state == ST_FETCH || state == ST_MEM) begin
            mem_req_o   <= 1'b1;
            mem_write_o <= (state == ST_MEM) && is_store;
        end
    end

    always_ff @(posedge CLK) begin
        if (!mem_req_o) begin
            mem_addr_o  <= (state == ST_MEM) ? alu_res_i : pc_i;
            mem_wdata_o <= store_data_i;
        end
    end

    a_req_hold: assert property (@(posedge CLK) disable iff (!RESET)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o)
            && $stable(mem_write_o) && $stable(mem_wdata_o));

    a_write_in_mem: assert property (@(posedge CLK) disable iff (!RESET)
        mem_write_o |-> state == ST_MEM);

endmodule

`default_nettype wire

// File: cpu/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    output logic            mem_req_o,
    output logic            mem_write_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    input  logic [XLEN-1:0] mem_rdata_i,
    input  logic            mem_ready_i
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_res;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    cpu_ctrl_if ctrl ();

    control_fsm u_fsm (
        .CLK          (CLK),
        .RESET        (RESET),
        .ctrl         (ctrl.fsm),
        .pc_i         (pc),
        .alu_res_i    (alu_res),
        .store_data_i (rs2_data),
        .mem_ready_i  (mem_ready_i),
        .mem_req_o    (mem_req_o),
        .mem_write_o  (mem_write_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

    pc_counter u_pc (
        .CLK   (CLK),
        .RESET (RESET),
        .ctrl  (ctrl.pc),
        .imm_i (imm),
        .pc_o  (pc)
    );

    inst_decode u_decode (
        .CLK         (CLK),
        .RESET       (RESET),
        .ctrl        (ctrl.decode),
        .mem_rdata_i (mem_rdata_i),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm)
    );

    reg_file u_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .ctrl        (ctrl.exec),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rd_i        (rd),
        .alu_res_i   (alu_res),
        .mem_rdata_i (mem_rdata_i),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data)
    );

    alu_unit u_alu (
        .CLK        (CLK),
        .RESET      (RESET),
        .ctrl       (ctrl.exec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .alu_res_o  (alu_res)
    );

endmodule

`default_nettype wire

// File: tb/tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    logic        CLK;
    logic        RESET;
    logic        mem_req;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_ready;

    // Program at 0x000-0x3FC, data at 0x400-0x7FC.
    logic [31:0] mem [512];
    logic [31:0] xreg [32];
    logic [31:0] model_pc;
    logic [31:0] lfsr;

    cpu_top DUT (
        .CLK         (CLK),
        .RESET       (RESET),
        .mem_req_o   (mem_req),
        .mem_write_o (mem_write),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [11:0] dimm;
        logic [12:0] off;
        logic [31:0] junk;
        kind = 4'(rand_bits(4));
        rd   = 5'(rand_bits(3));
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        imm  = 12'(rand_bits(12));
        dimm = 12'h400 | 12'(rand_bits(8) << 2);
        off  = 13'((rand_bits(3) + 32'd1) << 2);
        case (kind)
            4'd0, 4'd1: return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
            4'd2:       return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
            4'd3:       return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
            4'd4:       return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
            4'd5:       return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
            4'd6, 4'd7, 4'd14: return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
            4'd8, 4'd9: return {dimm, 5'd0, 3'b010, rd, OPC_LOAD};
            4'd10, 4'd11: return {dimm[11:5], rs2, 5'd0, 3'b010, dimm[4:0], OPC_STORE};
            4'd12, 4'd13: return {off[12], off[10:5], rs2, rs1, 2'b00, kind[0],
                                  off[4:1], off[11], OPC_BRANCH};
            default: begin
                // LUI, AUIPC, JAL and FENCE all run as no-ops here.
                junk = rand_bits(25);
                case (2'(rand_bits(2)))
                    2'd0:    return {junk[24:0], 7'b0110111};
                    2'd1:    return {junk[24:0], 7'b0010111};
                    2'd2:    return {junk[24:0], 7'b1101111};
                    default: return {junk[24:0], 7'b0001111};
                endcase
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_held(input logic [31:0] addr, input logic wr,
                              input logic [31:0] wdata);
        check_value("mem_req_o", 32'(mem_req), 32'd1);
        check_value("mem_addr_o", mem_addr, addr);
        check_value("mem_write_o", 32'(mem_write), 32'(wr));
        check_value("mem_wdata_o", mem_wdata, wdata);
    endtask

    // One bus transfer with 0 to 3 wait cycles.
    task automatic serve_transfer(output logic [31:0] addr, output logic wr,
                                  output logic [31:0] wdata);
        int cycles;
        int waits;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cycles > 40) begin
                report_timeout("a memory request for 40 cycles");
            end
        end while (!mem_req);
        addr  = mem_addr;
        wr    = mem_write;
        wdata = mem_wdata;
        waits = int'(rand_bits(2));
        for (int i = 0; i < waits; i++) begin
            @(posedge CLK);
            check_held(addr, wr, wdata);
        end
        mem_rdata <= mem[addr[10:2]];
        mem_ready <= 1'b1;
        @(posedge CLK);
        check_held(addr, wr, wdata);
        mem_ready <= 1'b0;
        if (wr) begin
            mem[addr[10:2]] = wdata;
        end
    endtask

    task automatic execute_inst(input logic [31:0] inst);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
        rd    = inst[11:7];
        f3    = inst[14:12];
        a     = xreg[inst[19:15]];
        b     = xreg[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        res   = '0;
        next_pc = model_pc + 32'd4;
        case (inst[6:0])
            OPC_OP: begin
                case (f3)
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: res = inst[30] ? a - b : a + b;
                endcase
            end
            OPC_OP_IMM: res = a + imm_i;
            OPC_LOAD: begin
                serve_transfer(addr, wr, wdata);
                check_value("mem_addr_o", addr, a + imm_i);
                check_value("mem_write_o", 32'(wr), 32'd0);
                res = mem[addr[10:2]];
            end
            OPC_STORE: begin
                serve_transfer(addr, wr, wdata);
                check_value("mem_addr_o", addr, a + imm_s);
                check_value("mem_write_o", 32'(wr), 32'd1);
                check_value("mem_wdata_o", wdata, b);
            end
            OPC_BRANCH: begin
                if ((f3[0] && a != b) || (!f3[0] && a == b)) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: begin
            end
        endcase
        if (rd != 5'd0 && (inst[6:0] == OPC_OP || inst[6:0] == OPC_OP_IMM ||
                           inst[6:0] == OPC_LOAD)) begin
            xreg[rd] = res;
        end
        model_pc = next_pc;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
        int          count;
        RESET     = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        lfsr      = 32'd88;
        for (int i = 0; i < 256; i++) begin
            mem[i] = gen_inst();
        end
        for (int i = 256; i < 512; i++) begin
            mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
        end
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        model_pc = '0;
        // Flops are settled after the first edge.
        for (int i = 0; i < 3; i++) begin
            @(posedge CLK);
            if (i > 0) begin
                check_value("mem_req_o", 32'(mem_req), 32'd0);
                check_value("mem_write_o", 32'(mem_write), 32'd0);
            end
        end
        RESET <= 1'b1;
        count = 0;
        while (count < 300 && model_pc < 32'h400) begin
            serve_transfer(addr, wr, wdata);
            check_value("mem_addr_o", addr, model_pc);
            check_value("mem_write_o", 32'(wr), 32'd0);
            execute_inst(mem[addr[10:2]]);
            count++;
        end
        $display("Retired %0d instructions, last pc 0x%08h", count, model_pc);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/cpu_pkg.sv
common/cpu_ctrl_if.sv
logic/pc_counter.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/alu_unit.sv
cpu/control_fsm.sv
cpu/cpu_top.sv
tb/tb_cpu_top.sv

// File: Makefile
SRCS := $(wildcard common/*.sv cpu/*.sv logic/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu_top: verilog.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps -f verilog.f \
		--top-module tb_cpu_top -o Vtb_cpu_top

run: obj_dir/Vtb_cpu_top
	@out="$$(./obj_dir/Vtb_cpu_top)"; echo "$$out"; \
		echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
